//--- compile.f
hw/motion_pkg.sv
hw/move_if.sv
hw/move_decode.sv
hw/player_motion.sv
hw/wb_status_regs.sv
hw/player_ctl_top.sv
verification/tb_clock.sv
verification/player_ctl_tb.sv

//--- hw/motion_pkg.sv
package motion_pkg;

    // horizontal pixel position of one player
    typedef logic [11:0] xpos_t;

    // movement FSM of one player
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // standing still
        RIGHT = 2'd1,  // facing or walking right
        LEFT  = 2'd2   // facing or walking left
    } player_state_t;

    // word address inside the status bank
    typedef logic [1:0] wb_addr_t;

    // wishbone data word
    typedef logic [15:0] wb_data_t;

    // frames seen since reset, wraps
    typedef logic [15:0] frame_cnt_t;

endpackage

//--- hw/move_decode.sv
`timescale 1ns/1ps

module move_decode (
    input  logic       clk,
    input  logic       rst,
    input  logic       v_tick,
    input  logic [1:0] m_left,
    input  logic [1:0] m_right,
    input  logic [1:0] button_pressed,
    move_if.decoder    mv
);

    logic       v_tick_q;     // sampled frame input
    logic       v_tick_prev;  // previous sample, for edge detect
    logic [1:0] m_left_q;
    logic [1:0] m_right_q;
    logic [1:0] button_q;
    logic       frame_rise;

    logic       tick_r;
    logic [1:0] go_right_r;
    logic [1:0] go_left_r;
    logic       gate_open_r;

    // input samples, aligned with v_tick_q
    always_ff @(posedge clk) begin
        m_left_q  <= m_left;
        m_right_q <= m_right;
        button_q  <= button_pressed;
    end

    assign frame_rise = v_tick_q && !v_tick_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            v_tick_q    <= 1'b0;
            v_tick_prev <= 1'b0;
            tick_r      <= 1'b0;
            go_right_r  <= '0;
            go_left_r   <= '0;
            gate_open_r <= 1'b0;
        end else begin
            v_tick_q    <= v_tick;
            v_tick_prev <= v_tick_q;
            tick_r      <= frame_rise;
            if (frame_rise) begin
                // right wins when both are pressed
                go_right_r  <= m_right_q;
                go_left_r   <= m_left_q & ~m_right_q;
                gate_open_r <= |button_q;   // either button opens the gate
            end
        end
    end

    assign mv.tick      = tick_r;
    assign mv.go_right  = go_right_r;
    assign mv.go_left   = go_left_r;
    assign mv.gate_open = gate_open_r;

endmodule

//--- hw/move_if.sv
`timescale 1ns/1ps

interface move_if;

    logic       tick;       // one-cycle pulse per frame
    logic [1:0] go_right;   // bit per player
    logic [1:0] go_left;    // never set together with go_right
    logic       gate_open;  // shared gate button

    // direction and gate values hold from one tick to the next
    modport decoder (
        output tick,
        output go_right,
        output go_left,
        output gate_open
    );

    modport mover (
        input tick,
        input go_right,
        input go_left,
        input gate_open
    );

endinterface

//--- hw/player_ctl_top.sv
`timescale 1ns/1ps

module player_ctl_top #(
    parameter int gate_left    = 310,
    parameter int gate_right   = 450,
    parameter int screen_right = 660,
    parameter int start_x_p1   = 500,
    parameter int start_x_p2   = 100
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 v_tick,
    input  logic [1:0]           m_left,
    input  logic [1:0]           m_right,
    input  logic [1:0]           button_pressed,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  motion_pkg::wb_addr_t adr,
    input  motion_pkg::wb_data_t dat_i,
    output motion_pkg::wb_data_t dat_o,
    output logic                 ack
);

    import motion_pkg::*;

    xpos_t         xpos_p1;
    xpos_t         xpos_p2;
    player_state_t state_p1;
    player_state_t state_p2;

    move_if mv_bus ();  // per-frame move command

    move_decode move_decode_inst (
        .clk            (clk),
        .rst            (rst),
        .v_tick         (v_tick),
        .m_left         (m_left),
        .m_right        (m_right),
        .button_pressed (button_pressed),
        .mv             (mv_bus.decoder)
    );

    player_motion #(
        .player_idx   (0),
        .start_x      (start_x_p1),
        .gate_left    (gate_left),
        .gate_right   (gate_right),
        .screen_right (screen_right)
    ) player_motion_p1 (
        .clk   (clk),
        .rst   (rst),
        .mv    (mv_bus.mover),
        .xpos  (xpos_p1),
        .state (state_p1)
    );

    player_motion #(
        .player_idx   (1),
        .start_x      (start_x_p2),
        .gate_left    (gate_left),
        .gate_right   (gate_right),
        .screen_right (screen_right)
    ) player_motion_p2 (
        .clk   (clk),
        .rst   (rst),
        .mv    (mv_bus.mover),
        .xpos  (xpos_p2),
        .state (state_p2)
    );

    // frame count follows the same tick as the movers
    wb_status_regs wb_status_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (mv_bus.tick),
        .xpos_p1  (xpos_p1),
        .xpos_p2  (xpos_p2),
        .state_p1 (state_p1),
        .state_p2 (state_p2),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .ack      (ack)
    );

endmodule

//--- hw/player_motion.sv
`timescale 1ns/1ps

module player_motion #(
    parameter int player_idx   = 0,
    parameter int start_x      = 500,
    parameter int gate_left    = 310,
    parameter int gate_right   = 450,
    parameter int screen_right = 660
) (
    input  logic                      clk,
    input  logic                      rst,
    move_if.mover                     mv,
    output motion_pkg::xpos_t         xpos,
    output motion_pkg::player_state_t state
);

    import motion_pkg::*;

    localparam xpos_t gate_lo   = xpos_t'(gate_left);
    localparam xpos_t gate_hi   = xpos_t'(gate_right);
    localparam xpos_t x_max     = xpos_t'(screen_right);
    localparam xpos_t x_initial = xpos_t'(start_x);

    logic          go_r;
    logic          go_l;
    xpos_t         dest_r;
    xpos_t         dest_l;
    logic          step_r_ok;
    logic          step_l_ok;
    xpos_t         xpos_nxt;
    player_state_t state_nxt;

    function automatic logic in_gate(input xpos_t x);
        return (x >= gate_lo) && (x <= gate_hi);
    endfunction

    // closed gate stops entry, but never stops a player already inside
    function automatic logic gate_blocks(input xpos_t dest, input xpos_t cur,
                                         input logic open);
        return !open && in_gate(dest) && !in_gate(cur);
    endfunction

    assign go_r = mv.go_right[player_idx];
    assign go_l = mv.go_left[player_idx];

    assign dest_r = xpos + 1'b1;
    assign dest_l = xpos - 1'b1;

    assign step_r_ok = (dest_r <= x_max) && !gate_blocks(dest_r, xpos, mv.gate_open);
    assign step_l_ok = (xpos != '0) && !gate_blocks(dest_l, xpos, mv.gate_open);

    always_comb begin
        state_nxt = state;
        xpos_nxt  = xpos;
        case (state)
            IDLE: begin
                // first tick only turns the player
                if (go_r) begin
                    state_nxt = RIGHT;
                end else if (go_l) begin
                    state_nxt = LEFT;
                end
            end
            RIGHT: begin
                if (go_r) begin
                    if (step_r_ok) begin
                        xpos_nxt = dest_r;
                    end
                end else begin
                    state_nxt = IDLE;  // released or reversed
                end
            end
            LEFT: begin
                if (go_l) begin
                    if (step_l_ok) begin
                        xpos_nxt = dest_l;
                    end
                end else begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            xpos  <= x_initial;
        end else if (mv.tick) begin  // one update per frame
            state <= state_nxt;
            xpos  <= xpos_nxt;
        end
    end

endmodule

//--- hw/wb_status_regs.sv
`timescale 1ns/1ps

module wb_status_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tick,
    input  motion_pkg::xpos_t         xpos_p1,
    input  motion_pkg::xpos_t         xpos_p2,
    input  motion_pkg::player_state_t state_p1,
    input  motion_pkg::player_state_t state_p2,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  motion_pkg::wb_addr_t      adr,
    input  motion_pkg::wb_data_t      dat_i,
    output motion_pkg::wb_data_t      dat_o,
    output logic                      ack
);

    import motion_pkg::*;

    frame_cnt_t frame_cnt;
    wb_data_t   rd_data;
    logic       req;

    // new request only while no ack is pending
    assign req = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (tick) begin
            frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
        end
    end

    always_comb begin
        case (adr)
            2'd0:    rd_data = wb_data_t'(xpos_p1);
            2'd1:    rd_data = wb_data_t'(xpos_p2);
            2'd2:    rd_data = {12'd0, state_p2, state_p1};
            default: rd_data = wb_data_t'(frame_cnt);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;  // one-cycle ack, writes included
        end
    end

    // read data valid together with ack
    always_ff @(posedge clk) begin
        if (req && !we) begin
            dat_o <= rd_data;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f compile.f --top-module player_ctl_tb \
    -o player_ctl_sim || { echo "verilator build failed"; exit 1; }
out="$(./obj_dir/player_ctl_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

//--- verification/player_ctl_tb.sv
`timescale 1ns/1ps

module player_ctl_tb;

    import motion_pkg::*;

    typedef struct packed {
        logic [1:0] m_left;
        logic [1:0] m_right;
        logic [1:0] button;
        logic [7:0] frames;     // frames run with these inputs
        xpos_t      exp_p1;
        xpos_t      exp_p2;
        wb_data_t   exp_state;  // p2 state in 3:2, p1 in 1:0
    } stim_row_t;

    localparam int num_rows = 7;
    localparam int ack_timeout = 20;

    logic       clk;
    logic       rst;
    logic       v_tick;
    logic [1:0] m_left;
    logic [1:0] m_right;
    logic [1:0] button_pressed;
    logic       cyc;
    logic       stb;
    logic       we;
    wb_addr_t   adr;
    wb_data_t   dat_i;
    wb_data_t   dat_o;
    logic       ack;

    stim_row_t  rows [num_rows];
    string      row_names [num_rows];

    tb_clock #(.period(8)) clock_gen (.clk(clk));

    player_ctl_top #(
        .gate_left    (10),
        .gate_right   (14),
        .screen_right (20),
        .start_x_p1   (8),
        .start_x_p2   (1)
    ) player_ctl_top_inst (
        .clk            (clk),
        .rst            (rst),
        .v_tick         (v_tick),
        .m_left         (m_left),
        .m_right        (m_right),
        .button_pressed (button_pressed),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_i          (dat_i),
        .dat_o          (dat_o),
        .ack            (ack)
    );

    // gate is 10..14, screen edge 20, p1 starts at 8 and p2 at 1
    task automatic load_table();
        row_names[0] = "after_reset";
        rows[0] = '{2'b00, 2'b00, 2'b00, 8'd0, 12'd8, 12'd1, 16'h0000};
        row_names[1] = "p1_right_gate_closed";
        rows[1] = '{2'b00, 2'b01, 2'b00, 8'd4, 12'd9, 12'd1, 16'h0001};
        row_names[2] = "p1_through_open_gate";
        rows[2] = '{2'b00, 2'b01, 2'b01, 8'd7, 12'd16, 12'd1, 16'h0001};
        row_names[3] = "release_all";
        rows[3] = '{2'b00, 2'b00, 2'b00, 8'd1, 12'd16, 12'd1, 16'h0000};
        row_names[4] = "p2_left_clamp_zero";
        rows[4] = '{2'b10, 2'b00, 2'b00, 8'd4, 12'd16, 12'd0, 16'h0008};
        row_names[5] = "both_right_priority";
        rows[5] = '{2'b11, 2'b11, 2'b00, 8'd3, 12'd18, 12'd1, 16'h0005};
        row_names[6] = "p1_clamp_screen_edge";
        rows[6] = '{2'b00, 2'b01, 2'b00, 8'd4, 12'd20, 12'd1, 16'h0001};
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive and sample away from the edge
    endtask

    task automatic run_frame();
        v_tick = 1'b1;
        repeat (4) next_cycle();
        v_tick = 1'b0;
        repeat (4) next_cycle();
    endtask

    task automatic wb_cycle(input logic write, input wb_addr_t addr,
                            input wb_data_t wdata, output wb_data_t rdata);
        int waited;
        waited = 0;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_i  = wdata;
        next_cycle();
        while (!ack) begin
            if (waited >= ack_timeout) begin
                $display("wishbone cycle to address %0d got no ack within %0d cycles",
                         addr, ack_timeout);
                $display("TEST RESULT: FAIL");
                $fatal(1, "wishbone ack timeout");
            end
            waited++;
            next_cycle();
        end
        rdata = dat_o;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        next_cycle();  // idle cycle between transfers
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t rdata);
        wb_cycle(1'b0, addr, 16'h0000, rdata);
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t wdata);
        wb_data_t unused;
        wb_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic check_xpos(input string name, input xpos_t expected, input xpos_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "position mismatch");
        end
    endtask

    task automatic check_state_word(input string name, input wb_data_t expected,
                                    input wb_data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "state word mismatch");
        end
    endtask

    task automatic check_count(input string name, input frame_cnt_t expected,
                               input frame_cnt_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "frame count mismatch");
        end
    endtask

    initial begin
        int       frames_total;
        wb_data_t rd;
        frames_total   = 0;
        rst            = 1'b1;
        v_tick         = 1'b0;
        m_left         = 2'b00;
        m_right        = 2'b00;
        button_pressed = 2'b00;
        cyc            = 1'b0;
        stb            = 1'b0;
        we             = 1'b0;
        adr            = 2'd0;
        dat_i          = 16'h0000;
        load_table();

        repeat (3) next_cycle();
        rst = 1'b0;
        next_cycle();

        for (int i = 0; i < num_rows; i++) begin
            m_left         = rows[i].m_left;
            m_right        = rows[i].m_right;
            button_pressed = rows[i].button;
            repeat (rows[i].frames) run_frame();
            frames_total += int'(rows[i].frames);

            wb_read(2'd0, rd);
            check_xpos({row_names[i], " p1 xpos"}, rows[i].exp_p1, xpos_t'(rd));
            wb_read(2'd1, rd);
            check_xpos({row_names[i], " p2 xpos"}, rows[i].exp_p2, xpos_t'(rd));
            wb_read(2'd2, rd);
            check_state_word({row_names[i], " states"}, rows[i].exp_state, rd);
            wb_read(2'd3, rd);
            check_count({row_names[i], " frame count"}, frame_cnt_t'(frames_total),
                        frame_cnt_t'(rd));
        end

        // write is acked but must leave the position alone
        wb_write(2'd0, 16'h0055);
        wb_read(2'd0, rd);
        check_xpos("write_ignored p1 xpos", rows[num_rows - 1].exp_p1, xpos_t'(rd));

        wb_read(2'd3, rd);
        check_count("frame_count", frame_cnt_t'(frames_total), frame_cnt_t'(rd));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 8  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule
